// File: pinmux_cfg_pkg.sv
/*
 * Pad configuration definitions for the pin multiplexer.
 * Holds the pad count, the 3-bit function select codes and the
 * per-pad and per-function vector types. Shared by the select
 * register cells, the routing blocks and the top level.
 */

package pinmux_cfg_pkg;

    // **************************************************
    // sizes
    // **************************************************
    localparam int N_PADS  = 12;
    localparam int N_FUNCS = 5;

    // **************************************************
    // function select codes
    // **************************************************
    // codes 5 and 6 are legal in the select register and act as off
    typedef enum logic [2:0] {
        FUNC_SPI0 = 3'd0,
        FUNC_SPI1 = 3'd1,
        FUNC_I2C0 = 3'd2,
        FUNC_I2C1 = 3'd3,
        FUNC_UART = 3'd4,
        FUNC_OFF  = 3'd7
    } pad_func_e;

    // pad index, wide enough for writes past the last pad
    typedef logic [3:0] pad_idx_t;

    // one bit per pad
    typedef logic [N_PADS-1:0] pad_vec_t;

    // one bit per routed function
    typedef logic [N_FUNCS-1:0] func_vec_t;

    // select value after reset
    localparam pad_func_e FUNC_RESET = FUNC_OFF;

endpackage

// File: pinmux_in_route.sv
/*
 * Input side of the pin multiplexer.
 * Turns on a pad's input enable when its current function reads
 * that pad, and hands each peripheral input its primary pad if
 * selected, else its alternate pad, else 0.
 */

`timescale 1ns/1ns

module pinmux_in_route
    import pinmux_cfg_pkg::*, pinmux_periph_pkg::*;
(
    input  pad_vec_t             pad_in_i,
    input  pad_func_e            pad_func_i [N_PADS],
    output pad_vec_t             pad_ie_o,
    output logic [SPI_LANES-1:0] spi0_sdi_o,
    output logic [SPI_LANES-1:0] spi1_sdi_o,
    output logic                 i2c0_scl_in_o,
    output logic                 i2c0_sda_in_o,
    output logic                 i2c1_scl_in_o,
    output logic                 i2c1_sda_in_o,
    output logic                 uart_rxd_o
);

    localparam pad_idx_t SPI0_SDI_PRI [SPI_LANES] = '{PAD_SPI0_SDI0_PRI, PAD_SPI0_SDI1_PRI};
    localparam pad_idx_t SPI0_SDI_ALT [SPI_LANES] = '{PAD_SPI0_SDI0_ALT, PAD_SPI0_SDI1_ALT};
    localparam pad_idx_t SPI1_SDI_PRI [SPI_LANES] = '{PAD_SPI1_SDI0_PRI, PAD_SPI1_SDI1_PRI};
    localparam pad_idx_t SPI1_SDI_ALT [SPI_LANES] = '{PAD_SPI1_SDI0_ALT, PAD_SPI1_SDI1_ALT};

    // pads each function reads
    pad_vec_t rd_mask [N_FUNCS];

    // primary wins over alternate, nothing selected reads 0
    function automatic logic pick(pad_idx_t pri, pad_idx_t alt, pad_func_e func);
        logic val;
        val = 1'b0;
        if (pad_func_i[pri] == func) begin
            val = pad_in_i[pri];
        end else if (pad_func_i[alt] == func) begin
            val = pad_in_i[alt];
        end
        return val;
    endfunction

    // **************************************************
    // read map and input enables
    // **************************************************
    always_comb begin
        for (int f = 0; f < N_FUNCS; f++) begin
            rd_mask[f] = '0;
        end
        for (int l = 0; l < SPI_LANES; l++) begin
            rd_mask[FUNC_SPI0][SPI0_SDI_PRI[l]] = 1'b1;
            rd_mask[FUNC_SPI0][SPI0_SDI_ALT[l]] = 1'b1;
            rd_mask[FUNC_SPI1][SPI1_SDI_PRI[l]] = 1'b1;
            rd_mask[FUNC_SPI1][SPI1_SDI_ALT[l]] = 1'b1;
        end
        rd_mask[FUNC_I2C0][PAD_I2C0_SDA_PRI] = 1'b1;
        rd_mask[FUNC_I2C0][PAD_I2C0_SDA_ALT] = 1'b1;
        rd_mask[FUNC_I2C0][PAD_I2C0_SCL_PRI] = 1'b1;
        rd_mask[FUNC_I2C0][PAD_I2C0_SCL_ALT] = 1'b1;
        rd_mask[FUNC_I2C1][PAD_I2C1_SDA_PRI] = 1'b1;
        rd_mask[FUNC_I2C1][PAD_I2C1_SDA_ALT] = 1'b1;
        rd_mask[FUNC_I2C1][PAD_I2C1_SCL_PRI] = 1'b1;
        rd_mask[FUNC_I2C1][PAD_I2C1_SCL_ALT] = 1'b1;
        rd_mask[FUNC_UART][PAD_UART_RXD_PRI] = 1'b1;
        rd_mask[FUNC_UART][PAD_UART_RXD_ALT] = 1'b1;
    end

    always_comb begin
        pad_ie_o = '0;
        for (int p = 0; p < N_PADS; p++) begin
            if (int'(pad_func_i[p]) < N_FUNCS) begin
                pad_ie_o[p] = rd_mask[pad_func_i[p]][p];
            end
        end
    end

    // **************************************************
    // peripheral inputs
    // **************************************************
    always_comb begin
        for (int l = 0; l < SPI_LANES; l++) begin
            spi0_sdi_o[l] = pick(SPI0_SDI_PRI[l], SPI0_SDI_ALT[l], FUNC_SPI0);
            spi1_sdi_o[l] = pick(SPI1_SDI_PRI[l], SPI1_SDI_ALT[l], FUNC_SPI1);
        end
        i2c0_sda_in_o = pick(PAD_I2C0_SDA_PRI, PAD_I2C0_SDA_ALT, FUNC_I2C0);
        i2c0_scl_in_o = pick(PAD_I2C0_SCL_PRI, PAD_I2C0_SCL_ALT, FUNC_I2C0);
        i2c1_sda_in_o = pick(PAD_I2C1_SDA_PRI, PAD_I2C1_SDA_ALT, FUNC_I2C1);
        i2c1_scl_in_o = pick(PAD_I2C1_SCL_PRI, PAD_I2C1_SCL_ALT, FUNC_I2C1);
        uart_rxd_o    = pick(PAD_UART_RXD_PRI, PAD_UART_RXD_ALT, FUNC_UART);
    end

endmodule

// File: pinmux_out_route.sv
/*
 * Output candidate builder for the pin multiplexer.
 * For every pad and every function code it places the peripheral
 * output value and output enable that the mapping table assigns
 * there. Empty table entries stay 0. The pad cells pick one bit.
 */

`timescale 1ns/1ns

module pinmux_out_route
    import pinmux_cfg_pkg::*, pinmux_periph_pkg::*;
(
    input  logic                 spi0_sclk_i,
    input  logic [SPI0_CS-1:0]   spi0_csn_i,
    input  logic [SPI_LANES-1:0] spi0_sdo_i,
    input  logic [SPI_LANES-1:0] spi0_oe_i,
    input  logic                 spi1_sclk_i,
    input  logic [SPI1_CS-1:0]   spi1_csn_i,
    input  logic [SPI_LANES-1:0] spi1_sdo_i,
    input  logic [SPI_LANES-1:0] spi1_oe_i,
    input  logic                 i2c0_scl_out_i,
    input  logic                 i2c0_scl_oe_i,
    input  logic                 i2c0_sda_out_i,
    input  logic                 i2c0_sda_oe_i,
    input  logic                 i2c1_scl_out_i,
    input  logic                 i2c1_scl_oe_i,
    input  logic                 i2c1_sda_out_i,
    input  logic                 i2c1_sda_oe_i,
    input  logic                 uart_txd_i,
    output func_vec_t            cand_out_o [N_PADS],
    output func_vec_t            cand_oe_o  [N_PADS]
);

    // per-lane and per-cs route tables
    localparam pad_idx_t SPI0_CS_PAD [SPI0_CS] = '{PAD_SPI0_CS0, PAD_SPI0_CS1, PAD_SPI0_CS2};
    localparam pad_idx_t SPI1_CS_PAD [SPI1_CS] = '{PAD_SPI1_CS0, PAD_SPI1_CS1};
    localparam pad_idx_t SPI0_SDO_PRI [SPI_LANES] = '{PAD_SPI0_SDO0_PRI, PAD_SPI0_SDO1_PRI};
    localparam pad_idx_t SPI0_SDO_ALT [SPI_LANES] = '{PAD_SPI0_SDO0_ALT, PAD_SPI0_SDO1_ALT};
    localparam pad_idx_t SPI1_SDO_PRI [SPI_LANES] = '{PAD_SPI1_SDO0_PRI, PAD_SPI1_SDO1_PRI};
    localparam pad_idx_t SPI1_SDO_ALT [SPI_LANES] = '{PAD_SPI1_SDO0_ALT, PAD_SPI1_SDO1_ALT};

    always_comb begin
        for (int p = 0; p < N_PADS; p++) begin
            cand_out_o[p] = '0;
            cand_oe_o[p]  = '0;
        end

        // clocks and chip selects always drive
        cand_out_o[PAD_SPI0_SCLK][FUNC_SPI0] = spi0_sclk_i;
        cand_oe_o[PAD_SPI0_SCLK][FUNC_SPI0]  = 1'b1;
        cand_out_o[PAD_SPI1_SCLK][FUNC_SPI1] = spi1_sclk_i;
        cand_oe_o[PAD_SPI1_SCLK][FUNC_SPI1]  = 1'b1;
        for (int c = 0; c < SPI0_CS; c++) begin
            cand_out_o[SPI0_CS_PAD[c]][FUNC_SPI0] = spi0_csn_i[c];
            cand_oe_o[SPI0_CS_PAD[c]][FUNC_SPI0]  = 1'b1;
        end
        for (int c = 0; c < SPI1_CS; c++) begin
            cand_out_o[SPI1_CS_PAD[c]][FUNC_SPI1] = spi1_csn_i[c];
            cand_oe_o[SPI1_CS_PAD[c]][FUNC_SPI1]  = 1'b1;
        end

        // data lanes follow the lane's own oe, on both routes
        for (int l = 0; l < SPI_LANES; l++) begin
            cand_out_o[SPI0_SDO_PRI[l]][FUNC_SPI0] = spi0_sdo_i[l];
            cand_oe_o[SPI0_SDO_PRI[l]][FUNC_SPI0]  = spi0_oe_i[l];
            cand_out_o[SPI0_SDO_ALT[l]][FUNC_SPI0] = spi0_sdo_i[l];
            cand_oe_o[SPI0_SDO_ALT[l]][FUNC_SPI0]  = spi0_oe_i[l];
            cand_out_o[SPI1_SDO_PRI[l]][FUNC_SPI1] = spi1_sdo_i[l];
            cand_oe_o[SPI1_SDO_PRI[l]][FUNC_SPI1]  = spi1_oe_i[l];
            cand_out_o[SPI1_SDO_ALT[l]][FUNC_SPI1] = spi1_sdo_i[l];
            cand_oe_o[SPI1_SDO_ALT[l]][FUNC_SPI1]  = spi1_oe_i[l];
        end

        // i2c open-drain style, enable comes from the controller
        cand_out_o[PAD_I2C0_SDA_PRI][FUNC_I2C0] = i2c0_sda_out_i;
        cand_oe_o[PAD_I2C0_SDA_PRI][FUNC_I2C0]  = i2c0_sda_oe_i;
        cand_out_o[PAD_I2C0_SDA_ALT][FUNC_I2C0] = i2c0_sda_out_i;
        cand_oe_o[PAD_I2C0_SDA_ALT][FUNC_I2C0]  = i2c0_sda_oe_i;
        cand_out_o[PAD_I2C0_SCL_PRI][FUNC_I2C0] = i2c0_scl_out_i;
        cand_oe_o[PAD_I2C0_SCL_PRI][FUNC_I2C0]  = i2c0_scl_oe_i;
        cand_out_o[PAD_I2C0_SCL_ALT][FUNC_I2C0] = i2c0_scl_out_i;
        cand_oe_o[PAD_I2C0_SCL_ALT][FUNC_I2C0]  = i2c0_scl_oe_i;
        cand_out_o[PAD_I2C1_SDA_PRI][FUNC_I2C1] = i2c1_sda_out_i;
        cand_oe_o[PAD_I2C1_SDA_PRI][FUNC_I2C1]  = i2c1_sda_oe_i;
        cand_out_o[PAD_I2C1_SDA_ALT][FUNC_I2C1] = i2c1_sda_out_i;
        cand_oe_o[PAD_I2C1_SDA_ALT][FUNC_I2C1]  = i2c1_sda_oe_i;
        cand_out_o[PAD_I2C1_SCL_PRI][FUNC_I2C1] = i2c1_scl_out_i;
        cand_oe_o[PAD_I2C1_SCL_PRI][FUNC_I2C1]  = i2c1_scl_oe_i;
        cand_out_o[PAD_I2C1_SCL_ALT][FUNC_I2C1] = i2c1_scl_out_i;
        cand_oe_o[PAD_I2C1_SCL_ALT][FUNC_I2C1]  = i2c1_scl_oe_i;

        // uart tx
        cand_out_o[PAD_UART_TXD_PRI][FUNC_UART] = uart_txd_i;
        cand_oe_o[PAD_UART_TXD_PRI][FUNC_UART]  = 1'b1;
        cand_out_o[PAD_UART_TXD_ALT][FUNC_UART] = uart_txd_i;
        cand_oe_o[PAD_UART_TXD_ALT][FUNC_UART]  = 1'b1;
    end

endmodule

// File: pinmux_pad_cell.sv
/*
 * One multiplexed pad.
 * Keeps the pad's function select, loaded when a config write
 * names this pad, and picks the output value and enable of the
 * selected function. Unused codes and off drive 0 with no enable.
 */

`timescale 1ns/1ns

module pinmux_pad_cell
    import pinmux_cfg_pkg::*;
#(
    parameter pad_idx_t PAD_INDEX = 4'd0
) (
    input  logic      pclk,
    input  logic      rst_n_i,
    input  logic      cfg_we_i,
    input  pad_idx_t  cfg_pad_i,
    input  pad_func_e cfg_func_i,
    input  func_vec_t cand_out_i,
    input  func_vec_t cand_oe_i,
    output logic      pad_out_o,
    output logic      pad_oe_o,
    output pad_func_e func_o
);

    pad_func_e sel_q;

    // **************************************************
    // select register
    // **************************************************
    // writes past the last pad never match any cell
    always_ff @(posedge pclk) begin
        if (!rst_n_i) begin
            sel_q <= FUNC_RESET;
        end else if (cfg_we_i && (cfg_pad_i == PAD_INDEX)) begin
            sel_q <= cfg_func_i;
        end
    end

    // **************************************************
    // output mux
    // **************************************************
    always_comb begin
        pad_out_o = 1'b0;
        pad_oe_o  = 1'b0;
        // only codes below N_FUNCS have a candidate
        if (int'(sel_q) < N_FUNCS) begin
            pad_out_o = cand_out_i[sel_q];
            pad_oe_o  = cand_oe_i[sel_q];
        end
    end

    assign func_o = sel_q;

endmodule

// File: pinmux_periph_pkg.sv
/*
 * Peripheral side of the pin multiplexer.
 * Lane and chip-select counts of the SPI blocks, and the pad index
 * of every primary and alternate route. Output routes feed the
 * candidate builder, input routes feed the input gatherer.
 */

package pinmux_periph_pkg;

    import pinmux_cfg_pkg::*;

    localparam int SPI_LANES = 2;
    localparam int SPI0_CS   = 3;
    localparam int SPI1_CS   = 2;

    // **************************************************
    // output routes
    // **************************************************
    localparam pad_idx_t PAD_SPI0_SCLK     = 4'd0;
    localparam pad_idx_t PAD_SPI0_CS0      = 4'd1;
    localparam pad_idx_t PAD_SPI0_CS1      = 4'd4;
    localparam pad_idx_t PAD_SPI0_CS2      = 4'd7;
    localparam pad_idx_t PAD_SPI0_SDO0_PRI = 4'd2;
    localparam pad_idx_t PAD_SPI0_SDO0_ALT = 4'd8;
    localparam pad_idx_t PAD_SPI0_SDO1_PRI = 4'd5;
    localparam pad_idx_t PAD_SPI0_SDO1_ALT = 4'd10;

    localparam pad_idx_t PAD_SPI1_SCLK     = 4'd1;
    localparam pad_idx_t PAD_SPI1_CS0      = 4'd2;
    localparam pad_idx_t PAD_SPI1_CS1      = 4'd5;
    localparam pad_idx_t PAD_SPI1_SDO0_PRI = 4'd3;
    localparam pad_idx_t PAD_SPI1_SDO0_ALT = 4'd8;
    localparam pad_idx_t PAD_SPI1_SDO1_PRI = 4'd6;
    localparam pad_idx_t PAD_SPI1_SDO1_ALT = 4'd10;

    localparam pad_idx_t PAD_UART_TXD_PRI  = 4'd2;
    localparam pad_idx_t PAD_UART_TXD_ALT  = 4'd10;

    // i2c pads drive and read on the same route
    localparam pad_idx_t PAD_I2C0_SDA_PRI  = 4'd2;
    localparam pad_idx_t PAD_I2C0_SDA_ALT  = 4'd10;
    localparam pad_idx_t PAD_I2C0_SCL_PRI  = 4'd3;
    localparam pad_idx_t PAD_I2C0_SCL_ALT  = 4'd11;
    localparam pad_idx_t PAD_I2C1_SDA_PRI  = 4'd4;
    localparam pad_idx_t PAD_I2C1_SDA_ALT  = 4'd8;
    localparam pad_idx_t PAD_I2C1_SCL_PRI  = 4'd5;
    localparam pad_idx_t PAD_I2C1_SCL_ALT  = 4'd9;

    // **************************************************
    // input routes
    // **************************************************
    localparam pad_idx_t PAD_SPI0_SDI0_PRI = 4'd3;
    localparam pad_idx_t PAD_SPI0_SDI0_ALT = 4'd9;
    localparam pad_idx_t PAD_SPI0_SDI1_PRI = 4'd6;
    localparam pad_idx_t PAD_SPI0_SDI1_ALT = 4'd11;
    localparam pad_idx_t PAD_SPI1_SDI0_PRI = 4'd4;
    localparam pad_idx_t PAD_SPI1_SDI0_ALT = 4'd9;
    localparam pad_idx_t PAD_SPI1_SDI1_PRI = 4'd7;
    localparam pad_idx_t PAD_SPI1_SDI1_ALT = 4'd11;
    localparam pad_idx_t PAD_UART_RXD_PRI  = 4'd3;
    localparam pad_idx_t PAD_UART_RXD_ALT  = 4'd11;

endpackage

// File: pinmux_top.f
+incdir+.
pinmux_cfg_pkg.sv
pinmux_periph_pkg.sv
pinmux_out_route.sv
pinmux_pad_cell.sv
pinmux_in_route.sv
pinmux_top.sv
tb_pinmux_top.sv

// File: pinmux_top.sv
/*
 * Pin multiplexer top level.
 * Twelve shared pads, each with a select written by pad index.
 * Peripheral outputs go through the candidate builder into the
 * pad cells, pad inputs come back through the input router.
 */

`timescale 1ns/1ns

module pinmux_top
    import pinmux_cfg_pkg::*;
(
    input  logic       pclk,
    input  logic       rst_n_i,

    // select writes
    input  logic       cfg_we_i,
    input  pad_idx_t   cfg_pad_i,
    input  pad_func_e  cfg_func_i,

    // pads
    input  pad_vec_t   pad_in_i,
    output pad_vec_t   pad_out_o,
    output pad_vec_t   pad_oe_o,
    output pad_vec_t   pad_ie_o,

    // spi0, three chip selects
    input  logic       spi0_sclk_i,
    input  logic [2:0] spi0_csn_i,
    input  logic [1:0] spi0_sdo_i,
    input  logic [1:0] spi0_oe_i,
    output logic [1:0] spi0_sdi_o,

    // spi1, two chip selects
    input  logic       spi1_sclk_i,
    input  logic [1:0] spi1_csn_i,
    input  logic [1:0] spi1_sdo_i,
    input  logic [1:0] spi1_oe_i,
    output logic [1:0] spi1_sdi_o,

    input  logic       i2c0_scl_out_i,
    input  logic       i2c0_scl_oe_i,
    output logic       i2c0_scl_in_o,
    input  logic       i2c0_sda_out_i,
    input  logic       i2c0_sda_oe_i,
    output logic       i2c0_sda_in_o,

    input  logic       i2c1_scl_out_i,
    input  logic       i2c1_scl_oe_i,
    output logic       i2c1_scl_in_o,
    input  logic       i2c1_sda_out_i,
    input  logic       i2c1_sda_oe_i,
    output logic       i2c1_sda_in_o,

    input  logic       uart_txd_i,
    output logic       uart_rxd_o
);

    func_vec_t cand_out [N_PADS];
    func_vec_t cand_oe  [N_PADS];
    pad_func_e pad_func [N_PADS];

    // **************************************************
    // output candidates
    // **************************************************
    pinmux_out_route x_out_route (
        .spi0_sclk_i    (spi0_sclk_i),
        .spi0_csn_i     (spi0_csn_i),
        .spi0_sdo_i     (spi0_sdo_i),
        .spi0_oe_i      (spi0_oe_i),
        .spi1_sclk_i    (spi1_sclk_i),
        .spi1_csn_i     (spi1_csn_i),
        .spi1_sdo_i     (spi1_sdo_i),
        .spi1_oe_i      (spi1_oe_i),
        .i2c0_scl_out_i (i2c0_scl_out_i),
        .i2c0_scl_oe_i  (i2c0_scl_oe_i),
        .i2c0_sda_out_i (i2c0_sda_out_i),
        .i2c0_sda_oe_i  (i2c0_sda_oe_i),
        .i2c1_scl_out_i (i2c1_scl_out_i),
        .i2c1_scl_oe_i  (i2c1_scl_oe_i),
        .i2c1_sda_out_i (i2c1_sda_out_i),
        .i2c1_sda_oe_i  (i2c1_sda_oe_i),
        .uart_txd_i     (uart_txd_i),
        .cand_out_o     (cand_out),
        .cand_oe_o      (cand_oe)
    );

    // **************************************************
    // pad cells
    // **************************************************
    for (genvar g = 0; g < N_PADS; g++) begin : g_pad_cell
        pinmux_pad_cell #(
            .PAD_INDEX (pad_idx_t'(g))
        ) x_pad_cell (
            .pclk       (pclk),
            .rst_n_i    (rst_n_i),
            .cfg_we_i   (cfg_we_i),
            .cfg_pad_i  (cfg_pad_i),
            .cfg_func_i (cfg_func_i),
            .cand_out_i (cand_out[g]),
            .cand_oe_i  (cand_oe[g]),
            .pad_out_o  (pad_out_o[g]),
            .pad_oe_o   (pad_oe_o[g]),
            .func_o     (pad_func[g])
        );
    end

    // **************************************************
    // inputs back to the peripherals
    // **************************************************
    pinmux_in_route x_in_route (
        .pad_in_i      (pad_in_i),
        .pad_func_i    (pad_func),
        .pad_ie_o      (pad_ie_o),
        .spi0_sdi_o    (spi0_sdi_o),
        .spi1_sdi_o    (spi1_sdi_o),
        .i2c0_scl_in_o (i2c0_scl_in_o),
        .i2c0_sda_in_o (i2c0_sda_in_o),
        .i2c1_scl_in_o (i2c1_scl_in_o),
        .i2c1_sda_in_o (i2c1_sda_in_o),
        .uart_rxd_o    (uart_rxd_o)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the pin multiplexer testbench with Verilator and run it.
# Exits non-zero when the testbench reports a failure.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_pinmux_top \
    -f pinmux_top.f \
    -o sim_pinmux

./obj_dir/sim_pinmux > sim.log 2>&1
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi

if ! grep -q "PASS: all tests" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation passed"

// File: tb_pinmux_model.svh
/*
 * Reference model of the pin multiplexer mapping table.
 * Works from the testbench's shadow copy of the pad selects and the
 * peripheral outputs it drives. Included inside the testbench module,
 * so the functions see those signals directly.
 */

`ifndef TB_PINMUX_MODEL_SVH
`define TB_PINMUX_MODEL_SVH

// peripheral inputs in order: spi0 sdi0/1, spi1 sdi0/1,
// i2c0 sda/scl, i2c1 sda/scl, uart rxd
localparam int N_INPUTS = 9;
localparam int IN_PRI  [N_INPUTS] = '{3, 6, 4, 7, 2, 3, 4, 5, 3};
localparam int IN_ALT  [N_INPUTS] = '{9, 11, 9, 11, 10, 11, 8, 9, 11};
localparam int IN_CODE [N_INPUTS] = '{0, 0, 1, 1, 2, 2, 3, 3, 4};

function automatic string input_name(input int k);
    case (k)
        0: return "spi0_sdi0";
        1: return "spi0_sdi1";
        2: return "spi1_sdi0";
        3: return "spi1_sdi1";
        4: return "i2c0_sda_in";
        5: return "i2c0_scl_in";
        6: return "i2c1_sda_in";
        7: return "i2c1_scl_in";
        default: return "uart_rxd";
    endcase
endfunction

// {oe, out} that one table entry drives, empty entries give 0
function automatic logic [1:0] pad_drive(input int pad, input int code);
    logic [6:0] key;
    logic [1:0] r;
    key = {pad[3:0], code[2:0]};
    r = 2'b00;
    case (key)
        {4'd0, 3'd0}:  r = {1'b1, spi0_sclk};
        {4'd1, 3'd0}:  r = {1'b1, spi0_csn[0]};
        {4'd1, 3'd1}:  r = {1'b1, spi1_sclk};
        {4'd2, 3'd0}:  r = {spi0_oe[0], spi0_sdo[0]};
        {4'd2, 3'd1}:  r = {1'b1, spi1_csn[0]};
        {4'd2, 3'd2}:  r = {i2c0_sda_oe, i2c0_sda_out};
        {4'd2, 3'd4}:  r = {1'b1, uart_txd};
        {4'd3, 3'd1}:  r = {spi1_oe[0], spi1_sdo[0]};
        {4'd3, 3'd2}:  r = {i2c0_scl_oe, i2c0_scl_out};
        {4'd4, 3'd0}:  r = {1'b1, spi0_csn[1]};
        {4'd4, 3'd3}:  r = {i2c1_sda_oe, i2c1_sda_out};
        {4'd5, 3'd0}:  r = {spi0_oe[1], spi0_sdo[1]};
        {4'd5, 3'd1}:  r = {1'b1, spi1_csn[1]};
        {4'd5, 3'd3}:  r = {i2c1_scl_oe, i2c1_scl_out};
        {4'd6, 3'd1}:  r = {spi1_oe[1], spi1_sdo[1]};
        {4'd7, 3'd0}:  r = {1'b1, spi0_csn[2]};
        {4'd8, 3'd0}:  r = {spi0_oe[0], spi0_sdo[0]};
        {4'd8, 3'd1}:  r = {spi1_oe[0], spi1_sdo[0]};
        {4'd8, 3'd3}:  r = {i2c1_sda_oe, i2c1_sda_out};
        {4'd9, 3'd3}:  r = {i2c1_scl_oe, i2c1_scl_out};
        {4'd10, 3'd0}: r = {spi0_oe[1], spi0_sdo[1]};
        {4'd10, 3'd1}: r = {spi1_oe[1], spi1_sdo[1]};
        {4'd10, 3'd2}: r = {i2c0_sda_oe, i2c0_sda_out};
        {4'd10, 3'd4}: r = {1'b1, uart_txd};
        {4'd11, 3'd2}: r = {i2c0_scl_oe, i2c0_scl_out};
        default:       r = 2'b00;
    endcase
    return r;
endfunction

// entries marked "in" plus every i2c entry
function automatic logic pad_reads(input int pad, input int code);
    logic [6:0] key;
    key = {pad[3:0], code[2:0]};
    case (key)
        {4'd2, 3'd2}, {4'd3, 3'd0}, {4'd3, 3'd2}, {4'd3, 3'd4},
        {4'd4, 3'd1}, {4'd4, 3'd3}, {4'd5, 3'd3}, {4'd6, 3'd0},
        {4'd7, 3'd1}, {4'd8, 3'd3}, {4'd9, 3'd0}, {4'd9, 3'd1},
        {4'd9, 3'd3}, {4'd10, 3'd2}, {4'd11, 3'd0}, {4'd11, 3'd1},
        {4'd11, 3'd2}, {4'd11, 3'd4}: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

function automatic void expected_pads(output pad_vec_t out_v, output pad_vec_t oe_v,
                                      output pad_vec_t ie_v);
    logic [1:0] d;
    for (int p = 0; p < N_PADS; p++) begin
        d = pad_drive(p, int'(shadow[p]));
        out_v[p] = d[0];
        oe_v[p]  = d[1];
        ie_v[p]  = pad_reads(p, int'(shadow[p]));
    end
endfunction

// primary pad first, then alternate, else 0
function automatic logic routed_input(input int k);
    if (int'(shadow[IN_PRI[k]]) == IN_CODE[k]) begin
        return pad_in[IN_PRI[k]];
    end
    if (int'(shadow[IN_ALT[k]]) == IN_CODE[k]) begin
        return pad_in[IN_ALT[k]];
    end
    return 1'b0;
endfunction

`endif

// File: tb_pinmux_top.sv
/*
 * Testbench for the pin multiplexer top level.
 * Drives random select writes, pad inputs and peripheral outputs on
 * the falling clock edge and checks every pad and peripheral input
 * against the table model on the next falling edge.
 */

`timescale 1ns/1ns

module tb_pinmux_top
    import pinmux_cfg_pkg::*, pinmux_periph_pkg::*;
();

    localparam int RESET_CYCLES   = 2;
    localparam int T1_CYCLES      = 16;
    localparam int T2_CYCLES      = 400;
    localparam int T3_CYCLES      = N_PADS + 9 * 16;
    localparam int T4_CYCLES      = 2 * N_PADS;
    localparam int T5_CYCLES      = N_PADS + 8 + 1;
    localparam int TOTAL_CYCLES   = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
                                    + T4_CYCLES + T5_CYCLES + 2;
    localparam int TIMEOUT_CYCLES = 2 * TOTAL_CYCLES;

    logic pclk;
    logic rst_n;
    logic cfg_we;
    pad_idx_t cfg_pad;
    pad_func_e cfg_func;
    pad_vec_t pad_in;
    pad_vec_t pad_out;
    pad_vec_t pad_oe;
    pad_vec_t pad_ie;
    logic spi0_sclk;
    logic [SPI0_CS-1:0] spi0_csn;
    logic [SPI_LANES-1:0] spi0_sdo;
    logic [SPI_LANES-1:0] spi0_oe;
    logic [SPI_LANES-1:0] spi0_sdi;
    logic spi1_sclk;
    logic [SPI1_CS-1:0] spi1_csn;
    logic [SPI_LANES-1:0] spi1_sdo;
    logic [SPI_LANES-1:0] spi1_oe;
    logic [SPI_LANES-1:0] spi1_sdi;
    logic i2c0_scl_out, i2c0_scl_oe, i2c0_scl_in;
    logic i2c0_sda_out, i2c0_sda_oe, i2c0_sda_in;
    logic i2c1_scl_out, i2c1_scl_oe, i2c1_scl_in;
    logic i2c1_sda_out, i2c1_sda_oe, i2c1_sda_in;
    logic uart_txd;
    logic uart_rxd;

    // shadow of the select registers
    logic [2:0] shadow [N_PADS];

    string test_name;
    int err_cnt = 0;
    int check_cnt = 0;
    int test_err_start = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycle_cnt = 0;

    `include "tb_pinmux_model.svh"

    pinmux_top i_dut (
        .pclk           (pclk),
        .rst_n_i        (rst_n),
        .cfg_we_i       (cfg_we),
        .cfg_pad_i      (cfg_pad),
        .cfg_func_i     (cfg_func),
        .pad_in_i       (pad_in),
        .pad_out_o      (pad_out),
        .pad_oe_o       (pad_oe),
        .pad_ie_o       (pad_ie),
        .spi0_sclk_i    (spi0_sclk),
        .spi0_csn_i     (spi0_csn),
        .spi0_sdo_i     (spi0_sdo),
        .spi0_oe_i      (spi0_oe),
        .spi0_sdi_o     (spi0_sdi),
        .spi1_sclk_i    (spi1_sclk),
        .spi1_csn_i     (spi1_csn),
        .spi1_sdo_i     (spi1_sdo),
        .spi1_oe_i      (spi1_oe),
        .spi1_sdi_o     (spi1_sdi),
        .i2c0_scl_out_i (i2c0_scl_out),
        .i2c0_scl_oe_i  (i2c0_scl_oe),
        .i2c0_scl_in_o  (i2c0_scl_in),
        .i2c0_sda_out_i (i2c0_sda_out),
        .i2c0_sda_oe_i  (i2c0_sda_oe),
        .i2c0_sda_in_o  (i2c0_sda_in),
        .i2c1_scl_out_i (i2c1_scl_out),
        .i2c1_scl_oe_i  (i2c1_scl_oe),
        .i2c1_scl_in_o  (i2c1_scl_in),
        .i2c1_sda_out_i (i2c1_sda_out),
        .i2c1_sda_oe_i  (i2c1_sda_oe),
        .i2c1_sda_in_o  (i2c1_sda_in),
        .uart_txd_i     (uart_txd),
        .uart_rxd_o     (uart_rxd)
    );

    always #4 pclk = ~pclk;

    always @(posedge pclk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("run stopped, still going after %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // **************************************************
    // checks
    // **************************************************
    task automatic check_pad_vec(input string what, input pad_vec_t exp_v, input pad_vec_t act_v);
        check_cnt++;
        if (act_v !== exp_v) begin
            err_cnt++;
            $display("Error %s %s: expected %03h actual %03h", test_name, what, exp_v, act_v);
        end
    endtask

    task automatic check_bit(input string what, input logic exp_v, input logic act_v);
        check_cnt++;
        if (act_v !== exp_v) begin
            err_cnt++;
            $display("Error %s %s: expected %b actual %b", test_name, what, exp_v, act_v);
        end
    endtask

    function automatic logic periph_in(input int k);
        case (k)
            0: return spi0_sdi[0];
            1: return spi0_sdi[1];
            2: return spi1_sdi[0];
            3: return spi1_sdi[1];
            4: return i2c0_sda_in;
            5: return i2c0_scl_in;
            6: return i2c1_sda_in;
            7: return i2c1_scl_in;
            default: return uart_rxd;
        endcase
    endfunction

    // full compare of pads and peripheral inputs
    task automatic check_all();
        pad_vec_t out_v;
        pad_vec_t oe_v;
        pad_vec_t ie_v;
        expected_pads(out_v, oe_v, ie_v);
        check_pad_vec("pad_out", out_v, pad_out);
        check_pad_vec("pad_oe", oe_v, pad_oe);
        check_pad_vec("pad_ie", ie_v, pad_ie);
        for (int k = 0; k < N_INPUTS; k++) begin
            check_bit(input_name(k), routed_input(k), periph_in(k));
        end
    endtask

    // falling edge, outputs have settled since the last drive
    task automatic settle();
        @(negedge pclk);
        check_all();
    endtask

    // **************************************************
    // stimulus
    // **************************************************
    task automatic randomize_io();
        logic [31:0] r;
        r = $urandom;
        pad_in       = pad_vec_t'($urandom);
        spi0_sclk    = r[0];
        spi0_csn     = r[3:1];
        spi0_sdo     = r[5:4];
        spi0_oe      = r[7:6];
        spi1_sclk    = r[8];
        spi1_csn     = r[10:9];
        spi1_sdo     = r[12:11];
        spi1_oe      = r[14:13];
        i2c0_scl_out = r[15];
        i2c0_scl_oe  = r[16];
        i2c0_sda_out = r[17];
        i2c0_sda_oe  = r[18];
        i2c1_scl_out = r[19];
        i2c1_scl_oe  = r[20];
        i2c1_sda_out = r[21];
        i2c1_sda_oe  = r[22];
        uart_txd     = r[23];
    endtask

    task automatic drive_write(input pad_idx_t pad, input logic [2:0] code);
        cfg_we   = 1'b1;
        cfg_pad  = pad;
        cfg_func = pad_func_e'(code);
        if (int'(pad) < N_PADS) begin
            shadow[pad] = code;
        end
    endtask

    // address and code wander while the strobe is low
    task automatic drive_idle();
        cfg_we   = 1'b0;
        cfg_pad  = 4'($urandom);
        cfg_func = pad_func_e'(3'($urandom));
    endtask

    // src < 0 means the input must read 0
    task automatic watch_input(input int k, input int src, input string label);
        logic exp_v;
        repeat (4) begin
            settle();
            exp_v = (src >= 0) ? pad_in[src] : 1'b0;
            check_bit({input_name(k), label}, exp_v, periph_in(k));
            randomize_io();
            drive_idle();
        end
    endtask

    task automatic start_test(input string name);
        test_name      = name;
        test_err_start = err_cnt;
    endtask

    task automatic end_test();
        tests_run++;
        if (err_cnt == test_err_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, err_cnt - test_err_start);
        end
    endtask

    // **************************************************
    // test sequence
    // **************************************************
    initial begin
        pad_vec_t hold_out;
        pad_vec_t hold_oe;
        pad_vec_t hold_ie;
        void'($urandom(28624));
        pclk = 1'b0;
        rst_n = 1'b0;
        cfg_we = 1'b0;
        cfg_pad = '0;
        cfg_func = FUNC_OFF;
        pad_in = '0;
        {spi0_sclk, spi0_csn, spi0_sdo, spi0_oe} = '0;
        {spi1_sclk, spi1_csn, spi1_sdo, spi1_oe} = '0;
        {i2c0_scl_out, i2c0_scl_oe, i2c0_sda_out, i2c0_sda_oe} = '0;
        {i2c1_scl_out, i2c1_scl_oe, i2c1_sda_out, i2c1_sda_oe} = '0;
        uart_txd = 1'b0;
        for (int p = 0; p < N_PADS; p++) begin
            shadow[p] = 3'd7;
        end
        repeat (RESET_CYCLES) @(posedge pclk);
        @(negedge pclk);
        rst_n = 1'b1;

        start_test("reset");
        repeat (T1_CYCLES) begin
            settle();
            check_pad_vec("pad_oe", '0, pad_oe);
            check_pad_vec("pad_ie", '0, pad_ie);
            randomize_io();
            drive_idle();
        end
        end_test();

        start_test("random config");
        for (int i = 0; i < T2_CYCLES; i++) begin
            settle();
            randomize_io();
            if ($urandom_range(3) == 0) begin
                drive_write(4'($urandom_range(N_PADS - 1)), 3'($urandom_range(7)));
            end else begin
                drive_idle();
            end
        end
        end_test();

        // all pads off first so only the pads under test are selected
        start_test("input priority");
        for (int p = 0; p < N_PADS; p++) begin
            settle();
            drive_write(4'(p), 3'd7);
        end
        for (int k = 0; k < N_INPUTS; k++) begin
            settle();
            drive_write(4'(IN_PRI[k]), 3'(IN_CODE[k]));
            settle();
            drive_write(4'(IN_ALT[k]), 3'(IN_CODE[k]));
            watch_input(k, IN_PRI[k], " both selected");
            settle();
            drive_write(4'(IN_PRI[k]), 3'd7);
            watch_input(k, IN_ALT[k], " alternate only");
            settle();
            drive_write(4'(IN_ALT[k]), 3'd7);
            watch_input(k, -1, " none selected");
        end
        end_test();

        start_test("unused codes");
        for (int p = 0; p < N_PADS; p++) begin
            settle();
            randomize_io();
            drive_write(4'(p), 3'(5 + $urandom_range(1)));
        end
        repeat (N_PADS) begin
            settle();
            check_pad_vec("pad_out", '0, pad_out);
            check_pad_vec("pad_oe", '0, pad_oe);
            check_pad_vec("pad_ie", '0, pad_ie);
            randomize_io();
            drive_idle();
        end
        end_test();

        start_test("index range");
        for (int p = 0; p < N_PADS; p++) begin
            settle();
            randomize_io();
            drive_write(4'(p), 3'($urandom_range(4)));
        end
        for (int idx = N_PADS; idx < 16; idx++) begin
            settle();
            expected_pads(hold_out, hold_oe, hold_ie);
            drive_write(4'(idx), 3'($urandom_range(7)));
            settle();
            check_pad_vec("pad_out after write", hold_out, pad_out);
            check_pad_vec("pad_oe after write", hold_oe, pad_oe);
            check_pad_vec("pad_ie after write", hold_ie, pad_ie);
            drive_idle();
        end
        settle();
        end_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
